// ==== Bender.yml ====
package:
  name: mlp_noc

sources:
  - include_dirs:
      - include
    files:
      - src/mlp_noc_pkg.sv
      - src/fifo_queue.sv
      - src/dispatcher.sv
      - src/noc_router.sv
      - src/mvm.sv
      - src/collector.sv
      - src/mlp_noc_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - bench/mlp_noc_tb.sv

// ==== bench/mlp_noc_tb.sv ====
// testbench for the MLP network accelerator with reference model, scoreboard and watchdog
`timescale 1ns/1ps
`include "mlp_noc_macros.svh"

module mlp_noc_tb;

    typedef mlp_noc_pkg::vec_t [`MLP_LANES-1:0] mat_t;   // one vec_t per weight row

    localparam int CLK_PERIOD = 100;
    localparam int N_BYPASS   = 8;
    localparam int N_SINGLE   = 8;
    localparam int N_DOUBLE   = 8;
    localparam int N_BACKP    = 16;   // more than all buffers on the two-layer path
    localparam int WATCHDOG_CYCLES = 200 * (N_BYPASS + N_SINGLE + N_DOUBLE + N_BACKP) + 1000;
    localparam int LANE_MAX   = (1 << (`MLP_LANE_W - 1)) - 1;

    logic                   clk;
    logic                   reset;
    mlp_noc_pkg::noc_flit_t ififo_wdata;
    logic                   ififo_wen;
    logic                   ififo_rdy;
    mlp_noc_pkg::vec_t      ofifo_rdata;
    logic                   ofifo_ren;
    logic                   ofifo_rdy;

    mlp_noc_pkg::vec_t expected [$];   // scoreboard
    logic drain_en;
    int errors;
    int test_err_start;
    int tests_run;
    int tests_failed;
    int outputs_seen;
    int wait_cycles;
    mat_t w0;
    mat_t w1;
    mlp_noc_pkg::vec_t x;

    mlp_noc_top UUT (
        .clk         (clk),
        .reset       (reset),
        .ififo_wdata (ififo_wdata),
        .ififo_wen   (ififo_wen),
        .ififo_rdy   (ififo_rdy),
        .ofifo_rdata (ofifo_rdata),
        .ofifo_ren   (ofifo_ren),
        .ofifo_rdy   (ofifo_rdy)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // y[r] = clamp((sum of w[r][c] * v[c]) >>> shift, 0, max lane)
    function automatic mlp_noc_pkg::vec_t mvm_ref(input mat_t w, input mlp_noc_pkg::vec_t v);
        mlp_noc_pkg::vec_t  y;
        mlp_noc_pkg::lane_t wl;
        mlp_noc_pkg::lane_t vl;
        int acc;
        for (int r = 0; r < `MLP_LANES; r++) begin
            acc = 0;
            for (int c = 0; c < `MLP_LANES; c++) begin
                wl  = w[r][c*`MLP_LANE_W +: `MLP_LANE_W];
                vl  = v[c*`MLP_LANE_W +: `MLP_LANE_W];
                acc = acc + int'(wl) * int'(vl);
            end
            acc = acc >>> `MLP_SHIFT;
            if (acc < 0)
                acc = 0;
            else if (acc > LANE_MAX)
                acc = LANE_MAX;
            y[r*`MLP_LANE_W +: `MLP_LANE_W] = acc[`MLP_LANE_W-1:0];
        end
        return y;
    endfunction

    // lanes uniform in -span..span-1
    function automatic mlp_noc_pkg::vec_t rand_vec(input int span);
        mlp_noc_pkg::vec_t v;
        int lane;
        for (int c = 0; c < `MLP_LANES; c++) begin
            lane = int'($urandom_range(2 * span - 1, 0)) - span;
            v[c*`MLP_LANE_W +: `MLP_LANE_W] = lane[`MLP_LANE_W-1:0];
        end
        return v;
    endfunction

    function automatic mat_t rand_mat(input int span);
        mat_t m;
        for (int r = 0; r < `MLP_LANES; r++)
            m[r] = rand_vec(span);
        return m;
    endfunction

    function automatic mlp_noc_pkg::noc_flit_t make_flit(input mlp_noc_pkg::node_id_t dest,
                                                         input mlp_noc_pkg::flit_kind_t kind,
                                                         input mlp_noc_pkg::row_idx_t row,
                                                         input mlp_noc_pkg::vec_t data);
        mlp_noc_pkg::noc_flit_t f;
        f.data = data;
        f.dest = dest;
        f.kind = kind;
        f.row  = row;
        return f;
    endfunction

    task automatic check_vec(input string name, input mlp_noc_pkg::vec_t got,
                             input mlp_noc_pkg::vec_t exp);
        if (got !== exp) begin
            $display("ERROR at %0t ns: %s got %h expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("ERROR at %0t ns: %s got %b expected %b", $time, name, got, exp);
            errors++;
        end
    endtask

    // starts and returns 1 ns after a clock edge
    task automatic send_flit(input mlp_noc_pkg::noc_flit_t f);
        while (!ififo_rdy) begin
            @(posedge clk);
            #1;
        end
        ififo_wdata = f;
        ififo_wen   = 1'b1;
        @(posedge clk);
        #1;
        ififo_wen = 1'b0;
    endtask

    task automatic send_vector(input mlp_noc_pkg::node_id_t dest, input mlp_noc_pkg::vec_t v,
                               input mlp_noc_pkg::vec_t exp);
        expected.push_back(exp);
        send_flit(make_flit(dest, mlp_noc_pkg::FLIT_VECTOR, '0, v));
    endtask

    task automatic load_layer(input mlp_noc_pkg::node_id_t dest, input mat_t w);
        for (int r = 0; r < `MLP_LANES; r++)
            send_flit(make_flit(dest, mlp_noc_pkg::FLIT_WEIGHT, r, w[r]));
    endtask

    // wait for an empty scoreboard and idle so stray outputs show up
    task automatic wait_drain();
        while (expected.size() != 0)
            @(posedge clk);
        repeat (10) @(posedge clk);
        #1;
        check_bit("ofifo_rdy", ofifo_rdy, 1'b0);
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (errors == test_err_start) begin
            $display("%s: ok", name);
        end else begin
            tests_failed++;
            $display("%s: %0d mismatches", name, errors - test_err_start);
        end
        test_err_start = errors;
    endtask

    // pops each output and compares it with the scoreboard
    always begin
        @(posedge clk);
        #1;
        if (!reset && drain_en && ofifo_rdy === 1'b1) begin
            ofifo_ren = 1'b1;
            outputs_seen++;
            if (expected.size() == 0) begin
                $display("at %0t ns an output %h arrived while none was expected",
                         $time, ofifo_rdata);
                errors++;
            end else begin
                check_vec("ofifo_rdata", ofifo_rdata, expected.pop_front());
            end
        end else begin
            ofifo_ren = 1'b0;
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout, run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("test failed");
        $finish;
    end

    initial begin
        void'($urandom(32'h80712b79));
        clk            = 1'b0;
        reset          = 1'b1;
        ififo_wdata    = '0;
        ififo_wen      = 1'b0;
        ofifo_ren      = 1'b0;
        drain_en       = 1'b1;
        errors         = 0;
        test_err_start = 0;
        tests_run      = 0;
        tests_failed   = 0;
        outputs_seen   = 0;
        repeat (4) @(posedge clk);
        #1;
        reset = 1'b0;

        check_bit("ofifo_rdy", ofifo_rdy, 1'b0);
        check_bit("ififo_rdy", ififo_rdy, 1'b1);
        end_test("reset state");

        // weight flits sent between the vectors must vanish at the collector
        for (int i = 0; i < N_BYPASS; i++) begin
            x = rand_vec(128);
            send_vector(2'd3, x, x);
            if (i % 2 == 0)
                send_flit(make_flit(2'd3, mlp_noc_pkg::FLIT_WEIGHT, i, rand_vec(128)));
        end
        wait_drain();
        end_test("bypass");

        w1 = rand_mat(8);
        load_layer(2'd2, w1);
        for (int i = 0; i < N_SINGLE; i++) begin
            x = rand_vec(64);
            send_vector(2'd2, x, mvm_ref(w1, x));
        end
        wait_drain();
        end_test("single layer");

        w0 = rand_mat(8);
        w1 = rand_mat(8);
        load_layer(2'd1, w0);
        load_layer(2'd2, w1);
        for (int i = 0; i < N_DOUBLE; i++) begin
            x = rand_vec(64);
            send_vector(2'd1, x, mvm_ref(w1, mvm_ref(w0, x)));
        end
        wait_drain();
        end_test("two layers");

        drain_en = 1'b0;   // hold the output so the whole path backs up
        fork
            begin
                for (int i = 0; i < N_BACKP; i++) begin
                    x = rand_vec(64);
                    send_vector(2'd1, x, mvm_ref(w1, mvm_ref(w0, x)));
                end
            end
            begin
                wait_cycles = 0;
                while (ififo_rdy && wait_cycles < 200) begin
                    @(posedge clk);
                    #1;
                    wait_cycles++;
                end
                if (ififo_rdy) begin
                    $display("ififo_rdy never fell while the output was held");
                    errors++;
                end
                repeat (5) @(posedge clk);
                drain_en = 1'b1;
            end
        join
        wait_drain();
        end_test("back-pressure");

        $display("%0d tests, %0d failed, %0d outputs checked, %0d errors",
                 tests_run, tests_failed, outputs_seen, errors);
        if (errors == 0)
            $display("test passed");
        else
            $display("test failed");
        $finish;
    end

endmodule

// ==== filelist.f ====
+incdir+include
src/mlp_noc_pkg.sv
src/fifo_queue.sv
src/dispatcher.sv
src/noc_router.sv
src/mvm.sv
src/collector.sv
src/mlp_noc_top.sv
bench/mlp_noc_tb.sv

// ==== include/mlp_noc_macros.svh ====
// sizing macros for lanes, lane width, node count, host FIFO depth and result shift
`ifndef MLP_NOC_MACROS_SVH
`define MLP_NOC_MACROS_SVH

// lanes per vector, also rows per weight matrix
`define MLP_LANES 8

// width of one signed lane
`define MLP_LANE_W 8

// router nodes
// 0 dispatcher, 1 layer 0, 2 layer 1, 3 collector
`define MLP_NODES 4

// depth of the host input and output FIFOs
`define MLP_FIFO_DEPTH 4

// arithmetic right shift on each dot product
`define MLP_SHIFT 4

`endif

// ==== src/collector.sv ====
// network ejection into the host output FIFO, weight flits dropped
`timescale 1ns/1ps

module collector (
    input  logic                   clk,
    input  logic                   reset,
    input  mlp_noc_pkg::noc_flit_t rx_flit,
    input  logic                   rx_valid,
    output logic                   rx_ready,
    output mlp_noc_pkg::vec_t      ofifo_rdata,
    input  logic                   ofifo_ren,
    output logic                   ofifo_rdy
);
    mlp_noc_pkg::noc_flit_t head;
    logic is_vector;
    logic fifo_full;
    logic fifo_empty;

    assign is_vector = (rx_flit.kind == mlp_noc_pkg::FLIT_VECTOR);
    assign rx_ready  = !is_vector || !fifo_full;   // weights sink right away

    fifo_queue ofifo (
        .clk     (clk),
        .reset   (reset),
        .wr_data (rx_flit),
        .wr_en   (rx_valid && is_vector),
        .full    (fifo_full),
        .rd_data (head),
        .rd_en   (ofifo_ren),
        .empty   (fifo_empty)
    );

    assign ofifo_rdata = head.data;
    assign ofifo_rdy   = !fifo_empty;

endmodule

// ==== src/dispatcher.sv ====
// host input FIFO presenting its head flit on the router injection link
`timescale 1ns/1ps

module dispatcher (
    input  logic                   clk,
    input  logic                   reset,
    input  mlp_noc_pkg::noc_flit_t ififo_wdata,
    input  logic                   ififo_wen,
    output logic                   ififo_rdy,
    output mlp_noc_pkg::noc_flit_t tx_flit,
    output logic                   tx_valid,
    input  logic                   tx_ready
);
    logic fifo_full;
    logic fifo_empty;
    logic pop;

    // pop only when the router takes the head
    assign pop = tx_valid && tx_ready;

    fifo_queue ififo (
        .clk     (clk),
        .reset   (reset),
        .wr_data (ififo_wdata),
        .wr_en   (ififo_wen),
        .full    (fifo_full),
        .rd_data (tx_flit),
        .rd_en   (pop),
        .empty   (fifo_empty)
    );

    assign ififo_rdy = !fifo_full;     // host may write
    assign tx_valid  = !fifo_empty;

endmodule

// ==== src/fifo_queue.sv ====
// first-word-fall-through flit FIFO with read and write pointers and occupancy count
`timescale 1ns/1ps
`include "mlp_noc_macros.svh"

module fifo_queue (
    input  logic                   clk,
    input  logic                   reset,
    input  mlp_noc_pkg::noc_flit_t wr_data,
    input  logic                   wr_en,
    output logic                   full,
    output mlp_noc_pkg::noc_flit_t rd_data,
    input  logic                   rd_en,
    output logic                   empty
);
    localparam int DEPTH = `MLP_FIFO_DEPTH;
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    mlp_noc_pkg::noc_flit_t mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic do_wr;
    logic do_rd;

    assign full  = (count == CNT_W'(DEPTH));
    assign empty = (count == '0);
    assign do_wr = wr_en && !full;     // write into a full queue is dropped
    assign do_rd = rd_en && !empty;

    assign rd_data = mem[rd_ptr];      // head is always visible

    always_ff @(posedge clk) begin
        if (do_wr)
            mem[wr_ptr] <= wr_data;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr)
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (do_rd)
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// ==== src/mlp_noc_pkg.sv ====
// lane, vector, node id, row index and flit kind types, and the network flit struct
`include "mlp_noc_macros.svh"

package mlp_noc_pkg;

    // one signed lane
    typedef logic signed [`MLP_LANE_W-1:0] lane_t;

    // full vector, lane 0 in the low bits
    typedef logic [`MLP_LANES*`MLP_LANE_W-1:0] vec_t;

    typedef logic [$clog2(`MLP_NODES)-1:0] node_id_t;   // router node number
    typedef logic [$clog2(`MLP_LANES)-1:0] row_idx_t;   // weight row number

    typedef enum logic {
        FLIT_VECTOR = 1'b0,
        FLIT_WEIGHT = 1'b1
    } flit_kind_t;

    // network flit, also used as the host input word
    typedef struct packed {
        vec_t       data;
        node_id_t   dest;
        flit_kind_t kind;
        row_idx_t   row;    // only meaningful for weight flits
    } noc_flit_t;

endpackage

// ==== src/mlp_noc_top.sv ====
// top level with dispatcher, router, two MVM layers and collector
`timescale 1ns/1ps
`include "mlp_noc_macros.svh"

module mlp_noc_top (
    input  logic                   clk,
    input  logic                   reset,
    input  mlp_noc_pkg::noc_flit_t ififo_wdata,
    input  logic                   ififo_wen,
    output logic                   ififo_rdy,
    output mlp_noc_pkg::vec_t      ofifo_rdata,
    input  logic                   ofifo_ren,
    output logic                   ofifo_rdy
);
    // inject side: dispatcher, layer 0, layer 1
    mlp_noc_pkg::noc_flit_t inj_flit [`MLP_NODES-1];
    logic [`MLP_NODES-2:0]  inj_valid;
    logic [`MLP_NODES-2:0]  inj_ready;

    // eject side: layer 0, layer 1, collector
    mlp_noc_pkg::noc_flit_t ej_flit [`MLP_NODES-1];
    logic [`MLP_NODES-2:0]  ej_valid;
    logic [`MLP_NODES-2:0]  ej_ready;

    dispatcher dispatcher0 (
        .clk         (clk),
        .reset       (reset),
        .ififo_wdata (ififo_wdata),
        .ififo_wen   (ififo_wen),
        .ififo_rdy   (ififo_rdy),
        .tx_flit     (inj_flit[0]),
        .tx_valid    (inj_valid[0]),
        .tx_ready    (inj_ready[0])
    );

    noc_router router (
        .clk       (clk),
        .reset     (reset),
        .in_flit   (inj_flit),
        .in_valid  (inj_valid),
        .in_ready  (inj_ready),
        .out_flit  (ej_flit),
        .out_valid (ej_valid),
        .out_ready (ej_ready)
    );

    mvm #(.next_node(2'd2)) layer0 (   // results on to layer 1
        .clk      (clk),
        .reset    (reset),
        .rx_flit  (ej_flit[0]),
        .rx_valid (ej_valid[0]),
        .rx_ready (ej_ready[0]),
        .tx_flit  (inj_flit[1]),
        .tx_valid (inj_valid[1]),
        .tx_ready (inj_ready[1])
    );

    mvm #(.next_node(2'd3)) layer1 (   // results to the collector
        .clk      (clk),
        .reset    (reset),
        .rx_flit  (ej_flit[1]),
        .rx_valid (ej_valid[1]),
        .rx_ready (ej_ready[1]),
        .tx_flit  (inj_flit[2]),
        .tx_valid (inj_valid[2]),
        .tx_ready (inj_ready[2])
    );

    collector collector0 (
        .clk         (clk),
        .reset       (reset),
        .rx_flit     (ej_flit[2]),
        .rx_valid    (ej_valid[2]),
        .rx_ready    (ej_ready[2]),
        .ofifo_rdata (ofifo_rdata),
        .ofifo_ren   (ofifo_ren),
        .ofifo_rdy   (ofifo_rdy)
    );

endmodule

// ==== src/mvm.sv ====
// one MLP layer with weight rows, dot products, shift, ReLU, saturation and result register
`timescale 1ns/1ps
`include "mlp_noc_macros.svh"

module mvm #(
    parameter mlp_noc_pkg::node_id_t next_node = 2'd3
) (
    input  logic                   clk,
    input  logic                   reset,
    input  mlp_noc_pkg::noc_flit_t rx_flit,
    input  logic                   rx_valid,
    output logic                   rx_ready,
    output mlp_noc_pkg::noc_flit_t tx_flit,
    output logic                   tx_valid,
    input  logic                   tx_ready
);
    localparam int LANES    = `MLP_LANES;
    localparam int LANE_W   = `MLP_LANE_W;
    localparam int ACC_W    = 2 * LANE_W + $clog2(LANES);
    localparam int LANE_MAX = 2 ** (LANE_W - 1) - 1;

    mlp_noc_pkg::vec_t weights [LANES];   // one row per output lane
    mlp_noc_pkg::vec_t result;
    mlp_noc_pkg::vec_t result_q;
    logic is_weight;
    logic wt_take;
    logic vec_take;

    // signed dot product of one weight row with the input vector
    function automatic logic signed [ACC_W-1:0] dot_row(input mlp_noc_pkg::vec_t w,
                                                        input mlp_noc_pkg::vec_t x);
        logic signed [ACC_W-1:0] acc;
        logic signed [ACC_W-1:0] wa;
        logic signed [ACC_W-1:0] xa;
        acc = '0;
        for (int c = 0; c < LANES; c++) begin
            wa  = mlp_noc_pkg::lane_t'(w[c*LANE_W +: LANE_W]);
            xa  = mlp_noc_pkg::lane_t'(x[c*LANE_W +: LANE_W]);
            acc = acc + wa * xa;
        end
        return acc;
    endfunction

    // shift, then clamp into 0..LANE_MAX
    function automatic mlp_noc_pkg::lane_t relu_sat(input logic signed [ACC_W-1:0] acc);
        logic signed [ACC_W-1:0] shifted;
        shifted = acc >>> `MLP_SHIFT;
        if (shifted < 0)
            return '0;
        if (shifted > LANE_MAX)
            return mlp_noc_pkg::lane_t'(LANE_MAX);
        return mlp_noc_pkg::lane_t'(shifted);
    endfunction

    assign is_weight = (rx_flit.kind == mlp_noc_pkg::FLIT_WEIGHT);

    // weights always taken, vectors need a free result slot
    assign rx_ready = is_weight || !tx_valid || tx_ready;
    assign wt_take  = rx_valid && is_weight;
    assign vec_take = rx_valid && !is_weight && rx_ready;

    always_comb begin
        for (int r = 0; r < LANES; r++)
            result[r*LANE_W +: LANE_W] = relu_sat(dot_row(weights[r], rx_flit.data));
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int r = 0; r < LANES; r++)
                weights[r] <= '0;
        end else if (wt_take) begin
            weights[rx_flit.row] <= rx_flit.data;   // whole row at once
        end
    end

    always_ff @(posedge clk) begin
        if (reset)
            tx_valid <= 1'b0;
        else if (vec_take)
            tx_valid <= 1'b1;
        else if (tx_ready)
            tx_valid <= 1'b0;
    end

    always_ff @(posedge clk) begin
        if (vec_take)
            result_q <= result;
    end

    always_comb begin
        tx_flit      = '0;
        tx_flit.data = result_q;
        tx_flit.dest = next_node;
        tx_flit.kind = mlp_noc_pkg::FLIT_VECTOR;
    end

endmodule

// ==== src/noc_router.sv ====
// crossbar router with per-output round-robin arbitration and one-flit output registers
`timescale 1ns/1ps
`include "mlp_noc_macros.svh"

module noc_router (
    input  logic                   clk,
    input  logic                   reset,
    input  mlp_noc_pkg::noc_flit_t in_flit [`MLP_NODES-1],
    input  logic [`MLP_NODES-2:0]  in_valid,
    output logic [`MLP_NODES-2:0]  in_ready,
    output mlp_noc_pkg::noc_flit_t out_flit [`MLP_NODES-1],
    output logic [`MLP_NODES-2:0]  out_valid,
    input  logic [`MLP_NODES-2:0]  out_ready
);
    // inputs: dispatcher, layer 0, layer 1
    // outputs: layer 0, layer 1, collector, so output o serves node o+1
    localparam int N_PORTS = `MLP_NODES - 1;
    localparam int IDX_W   = $clog2(N_PORTS);

    logic [N_PORTS-1:0] req   [N_PORTS];   // per output, one bit per input
    logic [N_PORTS-1:0] grant [N_PORTS];
    logic [IDX_W-1:0]   rr_ptr  [N_PORTS];
    logic [IDX_W-1:0]   win_idx [N_PORTS];
    logic [N_PORTS-1:0] can_load;

    // first requester at or after the pointer
    function automatic logic [N_PORTS-1:0] rr_pick(input logic [N_PORTS-1:0] reqs,
                                                   input logic [IDX_W-1:0] ptr);
        logic [N_PORTS-1:0] gnt;
        logic found;
        int idx;
        gnt   = '0;
        found = 1'b0;
        for (int k = 0; k < N_PORTS; k++) begin
            idx = (int'(ptr) + k) % N_PORTS;
            if (!found && reqs[idx]) begin
                gnt[idx] = 1'b1;
                found    = 1'b1;
            end
        end
        return gnt;
    endfunction

    always_comb begin
        in_ready = '0;
        for (int o = 0; o < N_PORTS; o++) begin
            can_load[o] = !out_valid[o] || out_ready[o];
            for (int i = 0; i < N_PORTS; i++) begin
                req[o][i] = in_valid[i] &&
                            (in_flit[i].dest == mlp_noc_pkg::node_id_t'(o + 1));
            end
            grant[o]   = rr_pick(req[o], rr_ptr[o]);
            win_idx[o] = '0;
            for (int i = 0; i < N_PORTS; i++) begin
                if (grant[o][i]) begin
                    win_idx[o]  = IDX_W'(i);
                    in_ready[i] = can_load[o];
                end
            end
        end
        // node 0 has no output, such flits are swallowed
        for (int i = 0; i < N_PORTS; i++) begin
            if (in_flit[i].dest == '0)
                in_ready[i] = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= '0;
            for (int o = 0; o < N_PORTS; o++)
                rr_ptr[o] <= '0;
        end else begin
            for (int o = 0; o < N_PORTS; o++) begin
                if (can_load[o]) begin
                    out_valid[o] <= |grant[o];
                    if (|grant[o])   // winner goes to the back of the line
                        rr_ptr[o] <= (win_idx[o] == IDX_W'(N_PORTS - 1)) ? '0
                                                                         : win_idx[o] + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int o = 0; o < N_PORTS; o++) begin
            if (can_load[o] && |grant[o])
                out_flit[o] <= in_flit[win_idx[o]];
        end
    end

endmodule
